//--- sim/motion_tests.txt
# kind op unit arg_hi arg_lo x0 x1 x2 x3, numbers in hex, op and code as in fw_pkg
# rsp: x0 code, x1 data0, x2 lowest data1, x3 data1 span; idle: x2 cycles
# pins: x0 shutdown, x1 high cycles per channel one byte each (channel 0 lowest), x2 window
rsp   0 0 00000000 00000000 0 00000001 00040000 1
none  1 0 00000012 34560000 0 0        0        0
rsp   2 0 00000000 00000000 1 00000012 34560000 100
none  4 1 34560800 00050008 0 0        0        0
none  4 2 34560800 00010004 0 0        0        0
pins  0 0 00000000 00000000 0 00000000 c8       0
idle  0 0 00000000 00000000 0 0        800      0
pins  0 0 00000000 00000000 0 00020500 8        0
pins  0 0 00000000 00000000 0 000a1900 28       0
rsp   5 1 00000000 00000000 3 00000005 00000008 1
rsp   5 2 00000000 00000000 3 00000001 00000004 1
rsp   5 0 00000000 00000000 3 00000000 00000000 1
rsp   5 3 00000000 00000000 3 00000000 00000000 1
rsp   5 1 00000000 00000000 3 00000005 00000008 1
rsp   5 2 00000000 00000000 3 00000001 00000004 1
pins  0 0 00000000 00000000 0 000a1900 28       0
rsp   4 2 00000000 00010004 2 00000004 34560800 2000
pins  0 0 00000000 00000000 1 00000000 28       0
reset 0 0 00000000 00000000 0 0        0        0
pins  0 0 00000000 00000000 0 00000000 a        0
none  3 0 00000000 00000000 0 0        0        0
pins  0 0 00000000 00000000 1 00000000 14       0
none  4 0 00000200 00020004 0 0        0        0
none  5 0 00000000 00000000 0 0        0        0
idle  0 0 00000000 00000000 0 0        200      0
pins  0 0 00000000 00000000 1 00000000 10       0
rsp   0 0 00000000 00000000 0 00000001 00040000 1

//--- sources.f
logic/fw_pkg.sv
logic/cmd_dispatch.sv
logic/system_ctl.sv
logic/pwm_channel.sv
logic/rsp_arbiter.sv
logic/motion_top.sv
sim/tb_motion.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_motion -f sources.f

./obj_dir/Vtb_motion | tee sim.log

grep -qx "Result: PASSED" sim.log
echo "Pass message found in sim.log"

//--- sim/tb_motion.sv
module tb_motion;

	typedef struct packed {
		fw_pkg::cmd_t c;
		logic [31:0] x0;
		logic [31:0] x1;
		logic [31:0] x2;
		logic [31:0] x3;
	} test_rec_t;

	logic clk = 1'b0;
	logic rst_n;
	fw_pkg::cmd_t cmd;
	logic cmd_req;
	logic cmd_ack;
	fw_pkg::rsp_t rsp;
	logic rsp_req;
	logic rsp_ack;
	logic [fw_pkg::num_pwm-1:0] pwm_out;
	logic shutdown;

	string kind_q[$];
	test_rec_t rec_q[$];
	fw_pkg::rsp_t got_q[$]; // Filled by the response collector
	fw_pkg::rsp_t want_q[$];
	logic [31:0] span_q[$];
	logic loaded = 1'b0;

	motion_top dut_i (.*);

	always #20 clk = ~clk;

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped after the first failure");
	endtask

	task automatic load_tests();
		int fd;
		int n;
		string line;
		string kind;
		logic [31:0] op_f, unit_f, hi_f, lo_f, x0_f, x1_f, x2_f, x3_f;
		test_rec_t r;
		fd = $fopen("sim/motion_tests.txt", "r");
		if (fd == 0)
			stop_with_failure("Could not open the test file sim/motion_tests.txt");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n <= 0 || line.len() == 0 || line[0] == "#")
				continue;
			n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", kind, op_f, unit_f, hi_f, lo_f,
				x0_f, x1_f, x2_f, x3_f);
			if (n <= 0)
				continue; // Blank line
			if (n != 9)
				stop_with_failure($sformatf("Malformed line in the test file: %s", line));
			r.c.op = fw_pkg::opcode_e'(op_f[2:0]);
			r.c.unit = unit_f[fw_pkg::unit_bits-1:0];
			r.c.arg_hi = hi_f;
			r.c.arg_lo = lo_f;
			r.x0 = x0_f;
			r.x1 = x1_f;
			r.x2 = x2_f;
			r.x3 = x3_f;
			kind_q.push_back(kind);
			rec_q.push_back(r);
		end
		$fclose(fd);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		cmd_req <= 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	// Four-phase command transfer
	task automatic send_cmd(input fw_pkg::cmd_t c);
		@(posedge clk);
		cmd <= c;
		cmd_req <= 1'b1;
		@(negedge clk);
		while (!cmd_ack) @(negedge clk);
		@(posedge clk);
		cmd_req <= 1'b0;
		@(negedge clk);
		while (cmd_ack) @(negedge clk);
	endtask

	task automatic check_rsp(input fw_pkg::rsp_t got, input fw_pkg::rsp_t want,
		input logic [31:0] span);
		if (got.code != want.code || got.unit != want.unit || got.data0 != want.data0 ||
			got.data1 - want.data1 >= span)
			stop_with_failure($sformatf(
				"[ERROR] %0t: response %0d/%0d/%h/%h, expected %0d/%0d/%h/%h (data1 span %0h)",
				$time, got.code, got.unit, got.data0, got.data1,
				want.code, want.unit, want.data0, want.data1, span));
	endtask

	task automatic check_pins(input logic sd_want, input logic [31:0] high_want,
		input int window);
		int high [fw_pkg::num_pwm];
		for (int i = 0; i < fw_pkg::num_pwm; i++)
			high[i] = 0;
		repeat (window) begin
			@(negedge clk);
			if (shutdown !== sd_want)
				stop_with_failure($sformatf("[ERROR] %0t: shutdown is %b, expected %b",
					$time, shutdown, sd_want));
			for (int i = 0; i < fw_pkg::num_pwm; i++)
				high[i] += int'(pwm_out[i]);
		end
		for (int i = 0; i < fw_pkg::num_pwm; i++)
			if (high[i] != int'(high_want[8*i +: 8]))
				stop_with_failure($sformatf(
					"[ERROR] %0t: pwm_out[%0d] high %0d of %0d cycles, expected %0d",
					$time, i, high[i], window, high_want[8*i +: 8]));
	endtask

	// Replies may come back in any order and are matched by code and unit
	task automatic drain_responses();
		int hit;
		while (got_q.size() < want_q.size())
			@(negedge clk);
		repeat (50) @(negedge clk); // Room for a late extra reply
		if (got_q.size() != want_q.size())
			stop_with_failure($sformatf("Received %0d responses where %0d were expected",
				got_q.size(), want_q.size()));
		while (want_q.size() > 0) begin
			hit = -1;
			foreach (got_q[i])
				if (hit < 0 && got_q[i].code == want_q[0].code && got_q[i].unit == want_q[0].unit)
					hit = i;
			if (hit < 0)
				stop_with_failure($sformatf("No response with code %0d for unit %0d arrived",
					want_q[0].code, want_q[0].unit));
			check_rsp(got_q[hit], want_q[0], span_q[0]);
			got_q.delete(hit);
			void'(want_q.pop_front());
			void'(span_q.pop_front());
		end
	endtask

	task automatic run_record(input string kind, input test_rec_t r);
		fw_pkg::rsp_t want;
		if (kind == "rsp") begin
			want.code = fw_pkg::rsp_code_e'(r.x0[2:0]);
			// Only channel replies carry a unit number
			want.unit = (want.code == fw_pkg::rsp_pwm_state) ? r.c.unit : '0;
			want.data0 = r.x1;
			want.data1 = r.x2;
			want_q.push_back(want);
			span_q.push_back(r.x3);
			send_cmd(r.c);
		end else if (kind == "none") begin
			send_cmd(r.c);
		end else if (kind == "pins") begin
			drain_responses();
			check_pins(r.x0[0], r.x1, int'(r.x2));
		end else if (kind == "idle") begin
			repeat (int'(r.x2)) @(negedge clk);
		end else if (kind == "reset") begin
			drain_responses();
			apply_reset();
		end else begin
			stop_with_failure($sformatf("Unknown record kind %s in the test file", kind));
		end
	endtask

	initial begin : collect_rsp
		int unsigned delay;
		void'($urandom(32'h6870369c));
		rsp_ack <= 1'b0;
		forever begin
			@(negedge clk);
			if (rsp_req && !rsp_ack) begin
				got_q.push_back(rsp);
				delay = $urandom % 6;
				repeat (delay) @(posedge clk);
				@(posedge clk);
				rsp_ack <= 1'b1;
				@(negedge clk);
				while (rsp_req) @(negedge clk);
				@(posedge clk);
				rsp_ack <= 1'b0;
			end
		end
	end

	initial begin
		wait (loaded);
		repeat (rec_q.size() * 2000) @(posedge clk);
		stop_with_failure("Timeout: the test records did not complete in the allowed time");
	end

	initial begin
		rst_n <= 1'b0;
		cmd <= '0;
		cmd_req <= 1'b0;
		load_tests();
		loaded = 1'b1;
		apply_reset();
		foreach (rec_q[i])
			run_record(kind_q[i], rec_q[i]);
		drain_responses();
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- logic/motion_top.sv
module motion_top (
	input logic clk,
	input logic rst_n,
	input fw_pkg::cmd_t cmd,
	input logic cmd_req,
	output logic cmd_ack,
	output fw_pkg::rsp_t rsp,
	output logic rsp_req,
	input logic rsp_ack,
	output logic [fw_pkg::num_pwm-1:0] pwm_out,
	output logic shutdown
);

	fw_pkg::cmd_t cmd_q;
	logic sys_go;
	logic sys_busy;
	logic [fw_pkg::num_pwm-1:0] pwm_go;
	logic [fw_pkg::num_pwm-1:0] pwm_pending;
	logic [fw_pkg::num_pwm-1:0] pwm_take;
	logic [fw_pkg::num_pwm-1:0] missed;
	logic [63:0] now;
	fw_pkg::rsp_t sys_rsp;
	logic sys_pending;
	logic sys_take;
	fw_pkg::rsp_t pwm_rsp [fw_pkg::num_pwm];

	cmd_dispatch dispatch_i (
		.clk(clk),
		.rst_n(rst_n),
		.cmd(cmd),
		.cmd_req(cmd_req),
		.cmd_ack(cmd_ack),
		.sys_go(sys_go),
		.pwm_go(pwm_go),
		.cmd_q(cmd_q),
		.sys_busy(sys_busy),
		.pwm_pending(pwm_pending)
	);

	system_ctl system_i (
		.clk(clk),
		.rst_n(rst_n),
		.go(sys_go),
		.cmd(cmd_q),
		.busy(sys_busy),
		.now(now),
		.missed(missed),
		.shutdown(shutdown),
		.rsp(sys_rsp),
		.rsp_pending(sys_pending),
		.rsp_take(sys_take)
	);

	for (genvar i = 0; i < fw_pkg::num_pwm; i++) begin : gen_pwm
		pwm_channel pwm_i (
			.clk(clk),
			.rst_n(rst_n),
			.go(pwm_go[i]),
			.cmd(cmd_q),
			.idx(fw_pkg::unit_t'(i)),
			.now_lo(now[31:0]), // Channels schedule on the low word only
			.shutdown(shutdown),
			.pwm_out(pwm_out[i]),
			.missed(missed[i]),
			.rsp(pwm_rsp[i]),
			.rsp_pending(pwm_pending[i]),
			.rsp_take(pwm_take[i])
		);
	end

	rsp_arbiter arbiter_i (
		.clk(clk),
		.rst_n(rst_n),
		.sys_rsp(sys_rsp),
		.sys_pending(sys_pending),
		.sys_take(sys_take),
		.pwm_rsp(pwm_rsp),
		.pwm_pending(pwm_pending),
		.pwm_take(pwm_take),
		.rsp(rsp),
		.rsp_req(rsp_req),
		.rsp_ack(rsp_ack)
	);

endmodule

//--- logic/rsp_arbiter.sv
module rsp_arbiter (
	input logic clk,
	input logic rst_n,
	input fw_pkg::rsp_t sys_rsp,
	input logic sys_pending,
	output logic sys_take,
	input fw_pkg::rsp_t pwm_rsp [fw_pkg::num_pwm],
	input logic [fw_pkg::num_pwm-1:0] pwm_pending,
	output logic [fw_pkg::num_pwm-1:0] pwm_take,
	output fw_pkg::rsp_t rsp,
	output logic rsp_req,
	input logic rsp_ack
);

	typedef enum logic [1:0] {
		s_idle,
		s_req,
		s_drop
	} state_e;

	state_e state;
	fw_pkg::unit_t rr;
	fw_pkg::unit_t sel;
	logic found;
	logic [fw_pkg::num_pwm-1:0] one_hot;

	// Round-robin search starting at rr, nearest pending channel wins
	always_comb begin
		int j;
		found = 1'b0;
		sel = rr;
		for (int k = fw_pkg::num_pwm - 1; k >= 0; k--) begin
			j = (int'(rr) + k) % fw_pkg::num_pwm;
			if (pwm_pending[j]) begin
				found = 1'b1;
				sel = fw_pkg::unit_t'(j);
			end
		end
		one_hot = '0;
		one_hot[sel] = found;
	end

	assign sys_take = state == s_idle && sys_pending; // System first
	assign pwm_take = (state == s_idle && !sys_pending) ? one_hot : '0;

	always_ff @(posedge clk) begin
		if (sys_take)
			rsp <= sys_rsp;
		else if (|pwm_take)
			rsp <= pwm_rsp[sel];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= s_idle;
			rsp_req <= 1'b0;
			rr <= '0;
		end else begin
			case (state)
				s_idle: if (sys_take || |pwm_take) begin
					if (!sys_take)
						rr <= fw_pkg::unit_t'((int'(sel) + 1) % fw_pkg::num_pwm);
					rsp_req <= 1'b1;
					state <= s_req;
				end
				s_req: if (rsp_ack) begin
					rsp_req <= 1'b0;
					state <= s_drop;
				end
				s_drop: if (!rsp_ack) state <= s_idle; // Host done with this one
				default: state <= s_idle;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) rsp_req |=> $stable(rsp))
		else $error("rsp changed while rsp_req high");

endmodule

//--- logic/pwm_channel.sv
module pwm_channel (
	input logic clk,
	input logic rst_n,
	input logic go,
	input fw_pkg::cmd_t cmd,
	input fw_pkg::unit_t idx,
	input logic [31:0] now_lo,
	input logic shutdown,
	output logic pwm_out,
	output logic missed,
	output fw_pkg::rsp_t rsp,
	output logic rsp_pending,
	input logic rsp_take
);

	fw_pkg::pwm_cfg_t active;
	fw_pkg::pwm_cfg_t sched;
	logic [31:0] sched_time;
	logic sched_valid;
	logic [15:0] cnt;
	logic [31:0] lead;
	logic accept;
	logic is_set;
	logic is_query;

	assign accept = go && !shutdown; // Dead after shutdown
	assign is_set = accept && cmd.op == fw_pkg::op_set_pwm;
	assign is_query = accept && cmd.op == fw_pkg::op_query_pwm;
	// Wrapping distance to the schedule time, must be at least one tick
	assign lead = cmd.arg_hi - now_lo;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= '0;
			sched_valid <= 1'b0;
			cnt <= '0;
			pwm_out <= 1'b0;
			missed <= 1'b0;
			rsp_pending <= 1'b0;
		end else begin
			if (sched_valid && now_lo == sched_time) begin
				active <= sched;
				sched_valid <= 1'b0;
				cnt <= '0; // New period starts at the swap
			end else if ({1'b0, cnt} + 17'd1 >= {1'b0, active.cycle_ticks}) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 16'd1;
			end
			pwm_out <= !shutdown && cnt < active.on_ticks;
			if (is_set) begin
				if ($signed(lead) <= 0)
					missed <= 1'b1; // Sticky
				else
					sched_valid <= 1'b1;
			end
			if (is_query)
				rsp_pending <= 1'b1;
			else if (rsp_take)
				rsp_pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (is_set) begin
			sched <= fw_pkg::pwm_cfg_t'(cmd.arg_lo);
			sched_time <= cmd.arg_hi;
		end
		if (is_query) begin
			rsp.code <= fw_pkg::rsp_pwm_state;
			rsp.unit <= idx;
			rsp.data0 <= {16'd0, active.on_ticks};
			rsp.data1 <= {16'd0, active.cycle_ticks};
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) shutdown |=> !pwm_out)
		else $error("pwm_out high during shutdown");

endmodule

//--- logic/system_ctl.sv
module system_ctl (
	input logic clk,
	input logic rst_n,
	input logic go,
	input fw_pkg::cmd_t cmd,
	output logic busy,
	output logic [63:0] now,
	input logic [fw_pkg::num_pwm-1:0] missed,
	output logic shutdown,
	output fw_pkg::rsp_t rsp,
	output logic rsp_pending,
	input logic rsp_take
);

	typedef enum logic [1:0] {
		s_idle,
		s_exec,
		s_invol,
		s_hold
	} state_e;

	state_e state;
	fw_pkg::cmd_t cmd_r;
	logic [fw_pkg::num_pwm-1:0] missed_r;
	logic invol_start;

	assign busy = state != s_idle;

	// Host commands win, a missed schedule is picked up on the next idle cycle
	assign invol_start = state == s_idle && !go && !shutdown && |missed;

	always_ff @(posedge clk) begin
		if (state == s_idle && go)
			cmd_r <= cmd;
		if (invol_start)
			missed_r <= missed; // Shutdown reason
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= s_idle;
			now <= '0;
			shutdown <= 1'b0;
			rsp_pending <= 1'b0;
		end else begin
			now <= now + 64'd1;
			case (state)
				s_idle: begin
					if (go)
						state <= s_exec;
					else if (invol_start)
						state <= s_invol;
				end
				s_exec: begin
					case (cmd_r.op)
						fw_pkg::op_get_version, fw_pkg::op_get_time: begin
							rsp_pending <= 1'b1;
							state <= s_hold;
						end
						fw_pkg::op_sync_time: begin
							now <= {cmd_r.arg_hi, cmd_r.arg_lo}; // Loaded as is, no latency fixup
							state <= s_idle;
						end
						fw_pkg::op_shutdown: begin
							shutdown <= 1'b1; // Commanded, no reply
							state <= s_idle;
						end
						default: state <= s_idle;
					endcase
				end
				s_invol: begin
					rsp_pending <= 1'b1;
					shutdown <= 1'b1;
					state <= s_hold;
				end
				s_hold: if (rsp_take) begin
					rsp_pending <= 1'b0;
					state <= s_idle;
				end
				default: state <= s_idle;
			endcase
		end
	end

	// Reply payload, valid once rsp_pending rises
	always_ff @(posedge clk) begin
		if (state == s_exec) begin
			rsp.unit <= '0;
			if (cmd_r.op == fw_pkg::op_get_version) begin
				rsp.code <= fw_pkg::rsp_version;
				rsp.data0 <= 32'(fw_pkg::fw_version);
				// GPIO, PWM, stepper, endstop counts; no UARTs either
				rsp.data1 <= {8'd0, 8'(fw_pkg::num_pwm), 8'd0, 8'd0};
			end else begin
				rsp.code <= fw_pkg::rsp_time;
				rsp.data0 <= now[63:32];
				rsp.data1 <= now[31:0];
			end
		end else if (state == s_invol) begin
			rsp.code <= fw_pkg::rsp_shutdown;
			rsp.unit <= '0;
			rsp.data0 <= 32'(missed_r);
			rsp.data1 <= now[31:0];
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) shutdown |=> shutdown)
		else $error("shutdown cleared after being set");

endmodule

//--- logic/cmd_dispatch.sv
module cmd_dispatch (
	input logic clk,
	input logic rst_n,
	input fw_pkg::cmd_t cmd,
	input logic cmd_req,
	output logic cmd_ack,
	output logic sys_go,
	output logic [fw_pkg::num_pwm-1:0] pwm_go,
	output fw_pkg::cmd_t cmd_q,
	input logic sys_busy,
	input logic [fw_pkg::num_pwm-1:0] pwm_pending
);

	typedef enum logic [1:0] {
		s_idle,
		s_route,
		s_ack_hold
	} state_e;

	state_e state;
	logic to_sys;
	logic to_pwm;
	logic target_free;

	always_comb begin
		to_sys = 1'b0;
		to_pwm = 1'b0;
		case (cmd_q.op)
			fw_pkg::op_get_version, fw_pkg::op_sync_time,
			fw_pkg::op_get_time, fw_pkg::op_shutdown: to_sys = 1'b1;
			fw_pkg::op_set_pwm, fw_pkg::op_query_pwm: to_pwm = int'(cmd_q.unit) < fw_pkg::num_pwm;
			default: ;
		endcase
	end

	// Unknown opcodes and bad channel numbers count as free and are dropped
	assign target_free = to_sys ? !sys_busy :
		to_pwm ? !pwm_pending[cmd_q.unit] : 1'b1;

	always_ff @(posedge clk) begin
		if (state == s_idle && cmd_req)
			cmd_q <= cmd;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= s_idle;
			cmd_ack <= 1'b0;
			sys_go <= 1'b0;
			pwm_go <= '0;
		end else begin
			sys_go <= 1'b0;
			pwm_go <= '0;
			case (state)
				s_idle: if (cmd_req) state <= s_route;
				s_route: if (target_free) begin
					sys_go <= to_sys;
					if (to_pwm)
						pwm_go[cmd_q.unit] <= 1'b1;
					cmd_ack <= 1'b1; // Strobe and ack leave together
					state <= s_ack_hold;
				end
				s_ack_hold: if (!cmd_req) begin
					cmd_ack <= 1'b0;
					state <= s_idle;
				end
				default: state <= s_idle;
			endcase
		end
	end

	// Host side of the four-phase pair must see ack held until req drops
	assert property (@(posedge clk) disable iff (!rst_n) cmd_ack && cmd_req |=> cmd_ack)
		else $error("cmd_ack dropped while cmd_req high");

endmodule

//--- logic/fw_pkg.sv
package fw_pkg;

	// Build configuration
	localparam int num_pwm = 4;
	localparam int fw_version = 1;
	localparam int unit_bits = 2;

	typedef logic [unit_bits-1:0] unit_t;

	// Host command opcodes
	typedef enum logic [2:0] {
		op_get_version = 3'd0,
		op_sync_time = 3'd1,
		op_get_time = 3'd2,
		op_shutdown = 3'd3,
		op_set_pwm = 3'd4,
		op_query_pwm = 3'd5
	} opcode_e;

	// Reply codes sent back to the host
	typedef enum logic [2:0] {
		rsp_version = 3'd0,
		rsp_time = 3'd1,
		rsp_shutdown = 3'd2,
		rsp_pwm_state = 3'd3
	} rsp_code_e;

	// For op_set_pwm: arg_hi is the schedule time,
	// arg_lo holds on_ticks in the upper half and cycle_ticks in the lower half
	typedef struct packed {
		opcode_e op;
		unit_t unit;
		logic [31:0] arg_hi;
		logic [31:0] arg_lo;
	} cmd_t;

	typedef struct packed {
		rsp_code_e code;
		unit_t unit; // Zero for system replies
		logic [31:0] data0;
		logic [31:0] data1;
	} rsp_t;

	// Layout matches arg_lo of op_set_pwm
	typedef struct packed {
		logic [15:0] on_ticks;
		logic [15:0] cycle_ticks;
	} pwm_cfg_t;

endpackage
